// File: baud_tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

module baud_tick_gen import uart_pkg::*; #(
    parameter int BAUD_DIV = BAUD_DIV_DEFAULT
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    // wide enough to hold BAUD_DIV - 1 even for BAUD_DIV of 1
    localparam int CNT_W = $clog2(BAUD_DIV + 1);

    logic [CNT_W-1:0] div_cnt;

    // free running divider that wraps at BAUD_DIV - 1
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            tick <= 1'b0;
        end else begin
            // single cycle pulse on the wrap
            tick <= (div_cnt == CNT_W'(BAUD_DIV - 1));
            if (div_cnt == CNT_W'(BAUD_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + CNT_W'(1);
            end
        end
    end

endmodule : baud_tick_gen

`default_nettype wire

// File: calc_alu.sv
`timescale 1ns/10ps
`default_nettype none

module calc_alu import calc_pkg::*; (
    input  logic         clk,
    input  calc_cmd_t    alu_cmd,
    output calc_result_t alu_result
);

    calc_result_t a_ext;
    calc_result_t b_ext;

    // operands zero extended to result width
    assign a_ext = {8'h00, alu_cmd.a};
    assign b_ext = {8'h00, alu_cmd.b};

    always_ff @(posedge clk) begin
        case (alu_cmd.op)
            ADD: alu_result <= a_ext + b_ext;
            // wraps modulo 2^16 when b > a
            SUB: alu_result <= a_ext - b_ext;
            // 8x8 product always fits 16 bits
            MUL: alu_result <= a_ext * b_ext;
            DIV: begin
                if (alu_cmd.b == 8'h00) begin
                    alu_result <= DIV_ZERO_RESULT;
                end else begin
                    alu_result <= a_ext / b_ext;
                end
            end
            // unknown opcode
            default: alu_result <= '0;
        endcase
    end

endmodule : calc_alu

`default_nettype wire

// File: calc_checker.sv
`timescale 1ns/10ps
`default_nettype none

module calc_checker import uart_pkg::*; import calc_pkg::*; #(
    parameter int BIT_CLKS = 64
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    input  logic tx,
    output int   frames_expected,
    output int   frames_done,
    output int   tx_chars,
    output int   mismatch_errors,
    output int   protocol_errors
);

    // expected response bytes, oldest first
    uart_byte_t exp_q[$];

    function automatic logic line_level(input bit use_tx);
        return use_tx ? tx : rx;
    endfunction

    // 16-bit result rules of the calculator
    function automatic calc_result_t model_result(input calc_cmd_t c);
        int diff;
        diff = int'(c.a) - int'(c.b);
        case (c.op)
            ADD: model_result = 16'(int'(c.a) + int'(c.b));
            // two's complement truncation is the modulo 2^16 wrap
            SUB: model_result = 16'(diff);
            MUL: model_result = 16'(int'(c.a) * int'(c.b));
            DIV: begin
                if (c.b == 8'h00) begin
                    model_result = DIV_ZERO_RESULT;
                end else begin
                    model_result = 16'(int'(c.a) / int'(c.b));
                end
            end
            default: model_result = 16'h0000;
        endcase
    endfunction

    // one character, sampled at bit middles on the falling clock edge
    task automatic read_char(input bit use_tx, output uart_byte_t data, output bit started,
                             output bit stop_ok);
        data = '0;
        started = 1'b0;
        stop_ok = 1'b0;
        // hunt for the start edge
        while (reset || line_level(use_tx) !== 1'b0) begin
            @(negedge clk);
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        // start bit must still be low at its middle
        if (line_level(use_tx) == 1'b0) begin
            started = 1'b1;
            for (int i = 0; i < DATA_BITS; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                data[i] = line_level(use_tx);
            end
            repeat (BIT_CLKS) @(negedge clk);
            stop_ok = line_level(use_tx);
        end
    endtask

    // frame parser model on the command line
    initial begin : rx_model
        uart_byte_t b;
        bit started;
        bit stop_ok;
        bit in_frame;
        int count;
        calc_cmd_t cmd;
        calc_result_t res;
        in_frame = 1'b0;
        count = 0;
        cmd = '0;
        frames_expected = 0;
        forever begin
            read_char(1'b0, b, started, stop_ok);
            if (started) begin
                if (!in_frame) begin
                    // header opens a frame, anything else is noise
                    if (b == FRAME_HEADER) begin
                        in_frame = 1'b1;
                        count = 0;
                    end
                end else if (b == FRAME_END) begin
                    in_frame = 1'b0;
                    // only exactly three payload bytes get a response
                    if (count == PAYLOAD_LEN) begin
                        res = model_result(cmd);
                        exp_q.push_back(RESP_LEAD);
                        exp_q.push_back(cmd.a);
                        exp_q.push_back(cmd.b);
                        exp_q.push_back(cmd.op);
                        exp_q.push_back(res[15:8]);
                        exp_q.push_back(res[7:0]);
                        exp_q.push_back(FRAME_END);
                        exp_q.push_back(RESP_PAD);
                        frames_expected++;
                    end
                end else begin
                    if (count == 0) begin
                        cmd.a = b;
                    end else if (count == 1) begin
                        cmd.b = b;
                    end else if (count == 2) begin
                        cmd.op = b;
                    end
                    count++;
                end
            end
        end
    end

    // response line compare
    initial begin : tx_compare
        uart_byte_t b;
        uart_byte_t exp;
        bit started;
        bit stop_ok;
        int pos;
        pos = 0;
        frames_done = 0;
        tx_chars = 0;
        mismatch_errors = 0;
        protocol_errors = 0;
        forever begin
            read_char(1'b1, b, started, stop_ok);
            if (started) begin
                tx_chars++;
                if (!stop_ok) begin
                    protocol_errors++;
                    $display("Error at %0t: tx character %02h has no stop bit", $time, b);
                end
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("Error at %0t: byte %02h on tx with no response expected",
                             $time, b);
                end else begin
                    exp = exp_q.pop_front();
                    if (b !== exp) begin
                        mismatch_errors++;
                        $display("Mismatch at %0t: response byte %0d is %02h, expected %02h",
                                 $time, pos, b, exp);
                    end
                    pos++;
                    // eight bytes close one response frame
                    if (pos == RESP_LEN) begin
                        pos = 0;
                        frames_done++;
                    end
                end
            end
        end
    end

endmodule : calc_checker

`default_nettype wire

// File: calc_pkg.sv
`default_nettype none

package calc_pkg;

    // opcode byte values carried in a command frame
    typedef enum logic [7:0] {
        ADD = 8'd1,
        SUB = 8'd2,
        MUL = 8'd3,
        DIV = 8'd4
    } calc_op_t;

    // one decoded command
    // op stays a raw byte so unknown opcodes can be echoed back
    typedef struct packed {
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] op;
    } calc_cmd_t;

    // 16-bit arithmetic result
    typedef logic [15:0] calc_result_t;

    // command frame delimiters
    localparam logic [7:0] FRAME_HEADER = 8'h0C;
    localparam logic [7:0] FRAME_END = 8'h0A;

    // response frame lead and trailing pad bytes
    localparam logic [7:0] RESP_LEAD = 8'h20;
    localparam logic [7:0] RESP_PAD = 8'h00;

    // byte counts of both frames
    localparam int RESP_LEN = 8;
    localparam int PAYLOAD_LEN = 3;

    // saturated value returned for x / 0
    localparam calc_result_t DIV_ZERO_RESULT = 16'hFFFF;

endpackage : calc_pkg

`default_nettype wire

// File: cmd_frame_parser.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_frame_parser import uart_pkg::*; import calc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  uart_byte_t rx_byte,
    input  logic       rx_valid,
    output calc_cmd_t  cmd,
    output logic       cmd_req,
    input  logic       cmd_ack
);

    typedef enum logic {
        P_HUNT,
        P_PAYLOAD
    } parse_state_t;

    parse_state_t state;
    // payload byte count, stops at PAYLOAD_LEN + 1
    logic [2:0]   pay_cnt;
    calc_cmd_t    frame_q;
    logic         frame_ok;
    logic         busy;

    assign frame_ok = (pay_cnt == 3'(PAYLOAD_LEN));
    // previous handshake not fully closed
    assign busy = cmd_req || cmd_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= P_HUNT;
            pay_cnt <= '0;
            cmd_req <= 1'b0;
        end else begin
            if (cmd_req && cmd_ack) begin
                cmd_req <= 1'b0;
            end
            if (rx_valid) begin
                case (state)
                    P_HUNT: begin
                        // anything before the header is ignored
                        if (rx_byte == FRAME_HEADER) begin
                            state <= P_PAYLOAD;
                            pay_cnt <= '0;
                        end
                    end
                    P_PAYLOAD: begin
                        if (rx_byte == FRAME_END) begin
                            state <= P_HUNT;
                            // short, long or colliding frames are dropped
                            if (frame_ok && !busy) begin
                                cmd_req <= 1'b1;
                            end
                        end else if (pay_cnt <= 3'(PAYLOAD_LEN)) begin
                            pay_cnt <= pay_cnt + 3'd1;
                        end
                    end
                    default: state <= P_HUNT;
                endcase
            end
        end
    end

    // payload collection, order is a, b, opcode
    always_ff @(posedge clk) begin
        if (rx_valid && state == P_PAYLOAD && rx_byte != FRAME_END) begin
            case (pay_cnt)
                3'd0: frame_q.a <= rx_byte;
                3'd1: frame_q.b <= rx_byte;
                3'd2: frame_q.op <= rx_byte;
                default: frame_q <= frame_q;
            endcase
        end
    end

    // presented command held stable while the next frame builds
    always_ff @(posedge clk) begin
        if (rx_valid && state == P_PAYLOAD && rx_byte == FRAME_END && frame_ok && !busy) begin
            cmd <= frame_q;
        end
    end

endmodule : cmd_frame_parser

`default_nettype wire

// File: flist.f
uart_pkg.sv
calc_pkg.sv
baud_tick_gen.sv
uart_rx.sv
uart_tx.sv
cmd_frame_parser.sv
calc_alu.sv
response_sender.sv
uart_calc_top.sv
calc_checker.sv
tb_uart_calc.sv

// File: response_sender.sv
`timescale 1ns/10ps
`default_nettype none

module response_sender import uart_pkg::*; import calc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  calc_cmd_t  cmd,
    input  logic       cmd_req,
    output logic       cmd_ack,
    output uart_byte_t tx_byte,
    output logic       tx_req,
    input  logic       tx_ack
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ALU,
        S_CAPTURE,
        S_SEND,
        S_DRAIN
    } send_state_t;

    send_state_t  state;
    calc_cmd_t    alu_cmd;
    calc_result_t alu_result;
    calc_result_t result_q;
    logic [2:0]   byte_idx;

    calc_alu alu_i (
        .clk        (clk),
        .alu_cmd    (alu_cmd),
        .alu_result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            cmd_ack <= 1'b0;
            tx_req <= 1'b0;
            byte_idx <= '0;
        end else begin
            // close the command handshake once req drops
            if (cmd_ack && !cmd_req) begin
                cmd_ack <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (cmd_req && !cmd_ack) begin
                        state <= S_ALU;
                    end
                end
                // alu registers its result this clock
                S_ALU: begin
                    cmd_ack <= 1'b1;
                    state <= S_CAPTURE;
                end
                S_CAPTURE: begin
                    byte_idx <= '0;
                    tx_req <= 1'b1;
                    state <= S_SEND;
                end
                S_SEND: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    // next byte only after the transmitter drops ack
                    if (!tx_ack) begin
                        if (byte_idx == 3'(RESP_LEN - 1)) begin
                            state <= S_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 3'd1;
                            tx_req <= 1'b1;
                            state <= S_SEND;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // command and result held for the whole response
    always_ff @(posedge clk) begin
        if (state == S_IDLE && cmd_req && !cmd_ack) begin
            alu_cmd <= cmd;
        end
        if (state == S_CAPTURE) begin
            result_q <= alu_result;
        end
    end

    // response frame layout
    always_comb begin
        case (byte_idx)
            3'd0: tx_byte = RESP_LEAD;
            3'd1: tx_byte = alu_cmd.a;
            3'd2: tx_byte = alu_cmd.b;
            3'd3: tx_byte = alu_cmd.op;
            3'd4: tx_byte = result_q[15:8];
            3'd5: tx_byte = result_q[7:0];
            3'd6: tx_byte = FRAME_END;
            default: tx_byte = RESP_PAD;
        endcase
    end

endmodule : response_sender

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the uart calculator testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 --top-module tb_uart_calc -f flist.f \
    && ./obj_dir/Vtb_uart_calc > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log

# the log decides the result
grep -q "Test failed" sim.log && { echo "simulation reported errors"; exit 1; } \
    || { echo "simulation clean"; exit 0; }

// File: tb_uart_calc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uart_calc
    import uart_pkg::*;
    import calc_pkg::*;
();

    localparam int BAUD_DIV = 4;
    localparam int BIT_CLKS = BAUD_DIV * 16;
    localparam int CHAR_CLKS = BIT_CLKS * 10;
    // a full response is eight characters
    localparam int RESP_TIMEOUT = CHAR_CLKS * 12;
    localparam int QUIET_CLKS = CHAR_CLKS * 2;
    localparam logic [31:0] SEED = 32'he16b_2ecd;

    logic clk;
    logic reset;
    logic rx;
    logic tx;
    int   frames_expected;
    int   frames_done;
    int   tx_chars;
    int   mismatch_errors;
    int   protocol_errors;
    int   tb_errors;

    uart_calc_top #(
        .BAUD_DIV   (BAUD_DIV),
        .STOP_TICKS (STOP_TICKS_DEFAULT)
    ) dut_i (
        .clk   (clk),
        .reset (reset),
        .rx    (rx),
        .tx    (tx)
    );

    calc_checker #(
        .BIT_CLKS (BIT_CLKS)
    ) checker_i (
        .clk             (clk),
        .reset           (reset),
        .rx              (rx),
        .tx              (tx),
        .frames_expected (frames_expected),
        .frames_done     (frames_done),
        .tx_chars        (tx_chars),
        .mismatch_errors (mismatch_errors),
        .protocol_errors (protocol_errors)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // payload byte that cannot be taken for the terminator
    function automatic logic [7:0] rand_payload();
        logic [7:0] v;
        v = 8'($urandom());
        while (v == FRAME_END) begin
            v = 8'($urandom());
        end
        return v;
    endfunction

    // noise that never looks like a header
    function automatic logic [7:0] rand_noise();
        logic [7:0] v;
        v = 8'($urandom());
        while (v == FRAME_HEADER) begin
            v = 8'($urandom());
        end
        return v;
    endfunction

    function automatic logic [7:0] rand_unknown_op();
        logic [7:0] v;
        v = rand_payload();
        while (v >= 8'd1 && v <= 8'd4) begin
            v = rand_payload();
        end
        return v;
    endfunction

    // start bit, eight data bits lsb first, one stop bit
    task automatic send_char(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    // good command frame and the wait for its response
    task automatic send_frame(input logic [7:0] a, input logic [7:0] b, input logic [7:0] op);
        int done_before;
        int waited;
        done_before = frames_done;
        send_char(FRAME_HEADER);
        send_char(a);
        send_char(b);
        send_char(op);
        send_char(FRAME_END);
        waited = 0;
        while (frames_done == done_before && waited < RESP_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (frames_done == done_before) begin
            tb_errors++;
            $display("Error at %0t: no response to command a=%02h b=%02h op=%02h",
                     $time, a, b, op);
        end
    endtask

    // tx must stay idle for the whole window
    task automatic expect_quiet(input int clks, input string what);
        int start_chars;
        int n;
        start_chars = tx_chars;
        n = 0;
        while (n < clks && tx === 1'b1 && tx_chars == start_chars) begin
            @(negedge clk);
            n++;
        end
        if (n < clks) begin
            tb_errors++;
            $display("Error at %0t: tx line became active after %s", $time, what);
        end
    endtask

    initial begin
        logic [7:0] op_a;
        logic [7:0] op_b;
        clk = 1'b0;
        reset = 1'b1;
        rx = 1'b1;
        tb_errors = 0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // idle after reset
        expect_quiet(QUIET_CLKS * 2, "reset with no command");

        // noise before any header
        for (int i = 0; i < 4; i++) begin
            send_char(rand_noise());
        end
        expect_quiet(QUIET_CLKS, "bytes without a header");

        // add and sub alternate
        for (int i = 0; i < 8; i++) begin
            op_a = rand_payload();
            op_b = rand_payload();
            // every second sub has b above a so the difference wraps
            while (i % 4 == 3 && op_a >= op_b) begin
                op_a = rand_payload();
                op_b = rand_payload();
            end
            send_frame(op_a, op_b, (i % 2 == 0) ? 8'(ADD) : 8'(SUB));
        end

        // mul and div alternate
        // every third b is zero
        for (int i = 0; i < 9; i++) begin
            send_frame(rand_payload(), (i % 3 == 0) ? 8'h00 : rand_payload(),
                       (i % 2 == 0) ? 8'(MUL) : 8'(DIV));
        end

        // unknown opcodes with both range ends first
        send_frame(rand_payload(), rand_payload(), 8'h00);
        send_frame(rand_payload(), rand_payload(), 8'hFF);
        for (int i = 0; i < 3; i++) begin
            send_frame(rand_payload(), rand_payload(), rand_unknown_op());
        end

        // short frame
        send_char(FRAME_HEADER);
        send_char(rand_payload());
        send_char(rand_payload());
        send_char(FRAME_END);
        expect_quiet(QUIET_CLKS, "a two byte frame");

        // long frame
        send_char(FRAME_HEADER);
        for (int i = 0; i < 4; i++) begin
            send_char(rand_payload());
        end
        send_char(FRAME_END);
        expect_quiet(QUIET_CLKS, "a four byte frame");

        // parser recovered
        send_frame(rand_payload(), rand_payload(), 8'(SUB));
        send_frame(rand_payload(), 8'h00, 8'(DIV));

        if (frames_done != frames_expected) begin
            tb_errors++;
            $display("Error at %0t: %0d responses expected but %0d received",
                     $time, frames_expected, frames_done);
        end
        $display("errors: %0d mismatch, %0d protocol, %0d timeout or missing",
                 mismatch_errors, protocol_errors, tb_errors);
        if (mismatch_errors + protocol_errors + tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_uart_calc

`default_nettype wire

// File: uart_calc_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_calc_top import uart_pkg::*; import calc_pkg::*; #(
    parameter int BAUD_DIV = BAUD_DIV_DEFAULT,
    parameter int STOP_TICKS = STOP_TICKS_DEFAULT
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx
);

    logic       tick;
    uart_byte_t rx_byte;
    logic       rx_valid;
    calc_cmd_t  cmd;
    logic       cmd_req;
    logic       cmd_ack;
    uart_byte_t tx_byte;
    logic       tx_req;
    logic       tx_ack;

    // shared oversampling tick for both directions
    baud_tick_gen #(
        .BAUD_DIV (BAUD_DIV)
    ) baud_i (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    uart_rx #(
        .STOP_TICKS (STOP_TICKS)
    ) rx_i (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    cmd_frame_parser parser_i (
        .clk      (clk),
        .reset    (reset),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack)
    );

    // alu lives inside the sender
    response_sender sender_i (
        .clk     (clk),
        .reset   (reset),
        .cmd     (cmd),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack),
        .tx_byte (tx_byte),
        .tx_req  (tx_req),
        .tx_ack  (tx_ack)
    );

    uart_tx #(
        .STOP_TICKS (STOP_TICKS)
    ) tx_i (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .tx_byte (tx_byte),
        .tx_req  (tx_req),
        .tx_ack  (tx_ack),
        .tx      (tx)
    );

endmodule : uart_calc_top

`default_nettype wire

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

    // one character on the serial line
    typedef logic [7:0] uart_byte_t;

    // data bits per character, sent and received lsb first
    localparam int DATA_BITS = 8;

    // oversampling ticks spent in the stop bit
    // 16 ticks is one full bit time
    localparam int STOP_TICKS_DEFAULT = 16;

    // clocks per oversampling tick
    // 54 clocks at 100 MHz with 16x oversampling gives about 115200 baud
    localparam int BAUD_DIV_DEFAULT = 54;

endpackage : uart_pkg

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx import uart_pkg::*; #(
    parameter int STOP_TICKS = STOP_TICKS_DEFAULT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  logic       rx,
    output uart_byte_t rx_byte,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    logic [1:0] rx_sync;
    logic       rx_s;
    uart_byte_t shift_q;

    // two flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    assign rx_s = rx_sync[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // falling edge opens the start bit
                    if (!rx_s) begin
                        state <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        if (tick_cnt == 4'd7) begin
                            // half a bit in, line must still be low
                            // otherwise it was a glitch
                            tick_cnt <= '0;
                            bit_cnt <= '0;
                            state <= rx_s ? RX_IDLE : RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        if (tick_cnt == 4'd15) begin
                            tick_cnt <= '0;
                            if (bit_cnt == 3'(DATA_BITS - 1)) begin
                                state <= RX_STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 3'd1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        // middle of the stop bit, character done
                        if (tick_cnt == 4'(STOP_TICKS - 1)) begin
                            state <= RX_IDLE;
                            rx_valid <= 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data shifted in lsb first at each bit middle
    always_ff @(posedge clk) begin
        if (state == RX_DATA && tick && tick_cnt == 4'd15) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

    assign rx_byte = shift_q;

endmodule : uart_rx

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx import uart_pkg::*; #(
    parameter int STOP_TICKS = STOP_TICKS_DEFAULT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  uart_byte_t tx_byte,
    input  logic       tx_req,
    output logic       tx_ack,
    output logic       tx
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t  state;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    uart_byte_t shift_q;
    logic       bit_end;

    // one full bit time elapsed
    assign bit_end = tick && (tick_cnt == 4'd15);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt <= '0;
            tx_ack <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    // new request only once the last ack was released
                    if (tx_req && !tx_ack) begin
                        state <= TX_START;
                        tick_cnt <= '0;
                    end else if (tx_ack && !tx_req) begin
                        tx_ack <= 1'b0;
                    end
                end
                TX_START, TX_DATA: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 4'd1;
                    end
                    if (bit_end && state == TX_START) begin
                        state <= TX_DATA;
                        bit_cnt <= '0;
                    end else if (bit_end) begin
                        if (bit_cnt == 3'(DATA_BITS - 1)) begin
                            state <= TX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end
                TX_STOP: begin
                    if (tick) begin
                        // stop bit complete, report and hold ack
                        if (tick_cnt == 4'(STOP_TICKS - 1)) begin
                            state <= TX_IDLE;
                            tx_ack <= 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // load on accept, shift lsb first at each data bit end
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_req && !tx_ack) begin
            shift_q <= tx_byte;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    // line level from state, high when idle or in stop
    always_comb begin
        case (state)
            TX_START: tx = 1'b0;
            TX_DATA:  tx = shift_q[0];
            default:  tx = 1'b1;
        endcase
    end

endmodule : uart_tx

`default_nettype wire
